/* sfr_pkg.sv */
// Layouts assume the packed PicoRV32 bus and at most 32 registers of 32 bits
`default_nettype none

package sfr_pkg;

    // ------------------------------
    // Width types
    // ------------------------------
    typedef logic [31:0] word_t;     // Register contents and bus data
    typedef logic [31:0] addr_t;     // Byte address from the CPU
    typedef logic [3:0]  strb_t;     // One strobe per byte lane
    typedef logic [4:0]  reg_idx_t;  // Register index
    typedef logic [4:0]  bit_idx_t;  // Bit within a register

    // Addressing mode from address bits 8..7
    typedef enum logic [1:0] {
        MODE_WORD    = 2'd0,
        MODE_BIT_SET = 2'd1,
        MODE_BIT_CLR = 2'd2,
        MODE_NONE    = 2'd3   // Reads 0 and drops writes
    } addr_mode_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RESP  = 2'd1,      // Command out to the datapath
        ST_GUARD = 2'd2       // Ready cycle and valid is ignored
    } ctrl_state_t;

    // ------------------------------
    // Packed bus words
    // ------------------------------
    localparam int FWD_W = 69;
    localparam int RET_W = 33;

    localparam int FWD_VALID_BIT = 68;
    localparam int FWD_ADDR_MSB  = 67;
    localparam int FWD_ADDR_LSB  = 36;
    localparam int FWD_WDATA_MSB = 35;
    localparam int FWD_WDATA_LSB = 4;
    localparam int FWD_STRB_MSB  = 3;
    localparam int FWD_STRB_LSB  = 0;

    localparam int RET_READY_BIT = 32;
    localparam int RET_RDATA_MSB = 31;
    localparam int RET_RDATA_LSB = 0;

    // ------------------------------
    // Address fields
    // ------------------------------
    localparam int ADDR_BASE_MSB  = 31;
    localparam int ADDR_BASE_LSB  = 24;
    localparam int ADDR_BASE2_MSB = 23;
    localparam int ADDR_BASE2_LSB = 16;
    localparam int ADDR_ZERO_MSB  = 15;  // Must read as zero for a hit
    localparam int ADDR_ZERO_LSB  = 14;
    localparam int ADDR_BREG_MSB  = 13;  // Register index in bit modes
    localparam int ADDR_BREG_LSB  = 9;
    localparam int ADDR_MODE_MSB  = 8;
    localparam int ADDR_MODE_LSB  = 7;
    localparam int ADDR_WREG_MSB  = 6;   // Word register index or bit index
    localparam int ADDR_WREG_LSB  = 2;

endpackage

`default_nettype wire

/* sfr_ctrl.sv */
// One request at a time, fixed one-cycle response, no wait states; N_REGS from 1 to 32
`timescale 1ns/1ps
`default_nettype none

module sfr_ctrl import sfr_pkg::*; #(
    parameter logic [7:0] BASE_ADDR  = 8'h00,
    parameter logic [7:0] BASE2_ADDR = 8'h00,
    parameter int         N_REGS     = 4
) (
    input  wire             clk,
    input  wire             rst,
    input  wire [FWD_W-1:0] mem_fwd,
    output logic            mem_ready,
    output logic            wr_en,
    output reg_idx_t        wr_reg,
    output word_t           wr_data,
    output strb_t           wr_bytes,
    output logic            bit_op,
    output bit_idx_t        bit_idx,
    output logic            bit_val,
    output logic            rd_en,
    output reg_idx_t        rd_reg,
    output logic            rd_bit_mode,
    output bit_idx_t        rd_bit
);

    // Unpacked request
    logic        mem_valid;
    addr_t       mem_addr;
    word_t       mem_wdata;
    strb_t       mem_wstrb;

    // Decode results
    logic        base_hit;
    addr_mode_t  mode;
    reg_idx_t    sel_reg;
    bit_idx_t    sel_bit;
    logic        cmd_ok;
    logic        accept;

    ctrl_state_t state;

    // ------------------------------
    // Bus unpack and address decode
    // ------------------------------
    assign mem_valid = mem_fwd[FWD_VALID_BIT];
    assign mem_addr  = mem_fwd[FWD_ADDR_MSB:FWD_ADDR_LSB];
    assign mem_wdata = mem_fwd[FWD_WDATA_MSB:FWD_WDATA_LSB];
    assign mem_wstrb = mem_fwd[FWD_STRB_MSB:FWD_STRB_LSB];

    assign base_hit = (mem_addr[ADDR_BASE_MSB:ADDR_BASE_LSB] == BASE_ADDR)
                   && (mem_addr[ADDR_BASE2_MSB:ADDR_BASE2_LSB] == BASE2_ADDR)
                   && (mem_addr[ADDR_ZERO_MSB:ADDR_ZERO_LSB] == 2'b00);

    assign mode    = addr_mode_t'(mem_addr[ADDR_MODE_MSB:ADDR_MODE_LSB]);
    assign sel_bit = mem_addr[ADDR_WREG_MSB:ADDR_WREG_LSB];
    assign sel_reg = (mode == MODE_WORD) ? mem_addr[ADDR_WREG_MSB:ADDR_WREG_LSB]
                                         : mem_addr[ADDR_BREG_MSB:ADDR_BREG_LSB];

    // Out of range or unused mode still answers, just with no command
    assign cmd_ok = (mode != MODE_NONE) && (int'(sel_reg) < N_REGS);
    assign accept = (state == ST_IDLE) && mem_valid && base_hit;

    // ------------------------------
    // Response sequencing
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP:  state <= ST_GUARD;  // Datapath acts on this edge
                ST_GUARD: state <= ST_IDLE;   // Master still holds valid here
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // Command pulses and ready
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_ready <= 1'b0;
            wr_en     <= 1'b0;
            rd_en     <= 1'b0;
        end else begin
            mem_ready <= (state == ST_RESP);  // Lines up with registered rdata
            wr_en     <= accept && cmd_ok && (mem_wstrb != '0);
            rd_en     <= accept && cmd_ok;
        end
    end

    // Command payload captured once per request
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_reg   <= sel_reg;
            wr_data  <= mem_wdata;
            wr_bytes <= mem_wstrb;
            bit_op   <= (mode != MODE_WORD);
            bit_idx  <= sel_bit;
            bit_val  <= (mode == MODE_BIT_SET);
        end
    end

    // Read side shares the captured fields
    assign rd_reg      = wr_reg;
    assign rd_bit_mode = bit_op;
    assign rd_bit      = bit_idx;

endmodule

`default_nettype wire

/* sfr_regfile.sv */
// Indices are range checked upstream; reset loads INIT_STATE and strobes last one cycle
`timescale 1ns/1ps
`default_nettype none

module sfr_regfile import sfr_pkg::*; #(
    parameter int                 N_REGS     = 4,
    parameter word_t [N_REGS-1:0] INIT_STATE = '0
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 wr_en,
    input  wire reg_idx_t       wr_reg,
    input  wire word_t          wr_data,
    input  wire strb_t          wr_bytes,
    input  wire                 bit_op,
    input  wire bit_idx_t       bit_idx,
    input  wire                 bit_val,
    output word_t [N_REGS-1:0]  regs_out,
    output word_t [N_REGS-1:0]  wr_str
);

    word_t byte_mask;  // Strobes widened to bits
    word_t bit_mask;   // One-hot for bit modes
    word_t wr_mask;    // Bits touched by this write
    word_t wr_val;     // Value for the touched bits

    // ------------------------------
    // Write mask and value
    // ------------------------------
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            byte_mask[b*8 +: 8] = {8{wr_bytes[b]}};
        end
    end

    assign bit_mask = word_t'(1) << bit_idx;

    always_comb begin
        if (bit_op) begin
            wr_mask = bit_mask;
            wr_val  = {32{bit_val}};   // Set or clear, write data ignored
        end else begin
            wr_mask = byte_mask;
            wr_val  = wr_data;
        end
    end

    // ------------------------------
    // Storage and write strobes
    // ------------------------------
    always_ff @(posedge clk) begin
        wr_str <= '0;                  // Pulse only
        if (rst) begin
            regs_out <= INIT_STATE;
        end else if (wr_en) begin
            for (int r = 0; r < N_REGS; r++) begin
                if (wr_reg == reg_idx_t'(r)) begin
                    // Merge keeps the unmasked bits
                    regs_out[r] <= (regs_out[r] & ~wr_mask) | (wr_val & wr_mask);
                    wr_str[r]   <= wr_mask;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sfr_read_mux.sv */
// rdata is registered and stays zero unless rd_en was high the cycle before
`timescale 1ns/1ps
`default_nettype none

module sfr_read_mux import sfr_pkg::*; #(
    parameter int N_REGS = 4
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     rd_en,
    input  wire reg_idx_t           rd_reg,
    input  wire                     rd_bit_mode,
    input  wire bit_idx_t           rd_bit,
    input  wire word_t [N_REGS-1:0] regs_in,
    output word_t                   rdata
);

    word_t sel_word;

    // Register select
    always_comb begin
        sel_word = '0;
        for (int r = 0; r < N_REGS; r++) begin
            if (rd_reg == reg_idx_t'(r)) begin
                sel_word = regs_in[r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !rd_en) begin
            rdata <= '0;                              // Bus sees zero outside ready
        end else if (rd_bit_mode) begin
            rdata <= {31'd0, sel_word[rd_bit]};       // Single bit as 0 or 1
        end else begin
            rdata <= sel_word;
        end
    end

endmodule

`default_nettype wire

/* gpio_port.sv */
// Needs N_REGS of at least 4 and GPIO_W up to 32; pin bits above GPIO_W read as zero
`timescale 1ns/1ps
`default_nettype none

module gpio_port import sfr_pkg::*; #(
    parameter int N_REGS = 4,
    parameter int GPIO_W = 8
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire word_t [N_REGS-1:0] regs_out,
    input  wire word_t [N_REGS-1:0] wr_str,
    input  wire [GPIO_W-1:0]        gpio_in,
    output word_t [N_REGS-1:0]      regs_in,
    output logic [GPIO_W-1:0]       gpio_out,
    output logic [GPIO_W-1:0]       gpio_oe
);

    // Register map
    localparam int REG_OUT  = 0;
    localparam int REG_OE   = 1;
    localparam int REG_IN   = 2;
    localparam int REG_EDGE = 3;

    logic [GPIO_W-1:0] sync_q1;     // Metastability stage
    logic [GPIO_W-1:0] sync_q2;     // Synchronized pins
    logic [GPIO_W-1:0] sync_q3;     // Previous sample for edges
    logic [GPIO_W-1:0] rise;
    logic [GPIO_W-1:0] edge_flags;

    // ------------------------------
    // Pin drive
    // ------------------------------
    assign gpio_out = regs_out[REG_OUT][GPIO_W-1:0];
    assign gpio_oe  = regs_out[REG_OE][GPIO_W-1:0];

    // ------------------------------
    // Input sync and edge flags
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            sync_q3 <= '0;
        end else begin
            sync_q1 <= gpio_in;
            sync_q2 <= sync_q1;
            sync_q3 <= sync_q2;
        end
    end

    assign rise = sync_q2 & ~sync_q3;

    // Any write strobe on EDGE clears that flag
    always_ff @(posedge clk) begin
        if (rst) begin
            edge_flags <= '0;
        end else begin
            edge_flags <= (edge_flags & ~wr_str[REG_EDGE][GPIO_W-1:0]) | rise;  // Set wins
        end
    end

    // ------------------------------
    // Readback vector
    // ------------------------------
    always_comb begin
        regs_in = regs_out;                          // Spare registers read as stored
        regs_in[REG_OUT]               = '0;
        regs_in[REG_OUT][GPIO_W-1:0]   = gpio_out;
        regs_in[REG_OE]                = '0;
        regs_in[REG_OE][GPIO_W-1:0]    = gpio_oe;
        regs_in[REG_IN]                = '0;
        regs_in[REG_IN][GPIO_W-1:0]    = sync_q2;   // Pins, not the stored word
        regs_in[REG_EDGE]              = '0;
        regs_in[REG_EDGE][GPIO_W-1:0]  = edge_flags;
    end

endmodule

`default_nettype wire

/* sfr_gpio_top.sv */
// Packed PicoRV32 bus on the ports; ready after two edges; N_REGS at least 4
`timescale 1ns/1ps
`default_nettype none

module sfr_gpio_top import sfr_pkg::*; #(
    parameter logic [7:0]         BASE_ADDR  = 8'h40,
    parameter logic [7:0]         BASE2_ADDR = 8'h01,
    parameter int                 N_REGS     = 4,
    parameter word_t [N_REGS-1:0] INIT_STATE = '0,
    parameter int                 GPIO_W     = 8
) (
    input  wire              clk,
    input  wire              rst,
    input  wire [FWD_W-1:0]  mem_fwd,
    output logic [RET_W-1:0] mem_ret,
    input  wire [GPIO_W-1:0] gpio_in,
    output logic [GPIO_W-1:0] gpio_out,
    output logic [GPIO_W-1:0] gpio_oe
);

    // Controller to datapath
    logic               mem_ready;
    logic               wr_en;
    reg_idx_t           wr_reg;
    word_t              wr_data;
    strb_t              wr_bytes;
    logic               bit_op;
    bit_idx_t           bit_idx;
    logic               bit_val;
    logic               rd_en;
    reg_idx_t           rd_reg;
    logic               rd_bit_mode;
    bit_idx_t           rd_bit;

    // Datapath
    word_t              rdata;
    word_t [N_REGS-1:0] regs_out;
    word_t [N_REGS-1:0] wr_str;
    word_t [N_REGS-1:0] regs_in;

    // Return word
    assign mem_ret[RET_READY_BIT]               = mem_ready;
    assign mem_ret[RET_RDATA_MSB:RET_RDATA_LSB] = rdata;

    sfr_ctrl #(
        .BASE_ADDR  (BASE_ADDR),
        .BASE2_ADDR (BASE2_ADDR),
        .N_REGS     (N_REGS)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .mem_fwd     (mem_fwd),
        .mem_ready   (mem_ready),
        .wr_en       (wr_en),
        .wr_reg      (wr_reg),
        .wr_data     (wr_data),
        .wr_bytes    (wr_bytes),
        .bit_op      (bit_op),
        .bit_idx     (bit_idx),
        .bit_val     (bit_val),
        .rd_en       (rd_en),
        .rd_reg      (rd_reg),
        .rd_bit_mode (rd_bit_mode),
        .rd_bit      (rd_bit)
    );

    sfr_regfile #(
        .N_REGS     (N_REGS),
        .INIT_STATE (INIT_STATE)
    ) u_regfile (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_reg   (wr_reg),
        .wr_data  (wr_data),
        .wr_bytes (wr_bytes),
        .bit_op   (bit_op),
        .bit_idx  (bit_idx),
        .bit_val  (bit_val),
        .regs_out (regs_out),
        .wr_str   (wr_str)
    );

    sfr_read_mux #(
        .N_REGS (N_REGS)
    ) u_read_mux (
        .clk         (clk),
        .rst         (rst),
        .rd_en       (rd_en),
        .rd_reg      (rd_reg),
        .rd_bit_mode (rd_bit_mode),
        .rd_bit      (rd_bit),
        .regs_in     (regs_in),
        .rdata       (rdata)
    );

    gpio_port #(
        .N_REGS (N_REGS),
        .GPIO_W (GPIO_W)
    ) u_gpio (
        .clk      (clk),
        .rst      (rst),
        .regs_out (regs_out),
        .wr_str   (wr_str),
        .gpio_in  (gpio_in),
        .regs_in  (regs_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

endmodule

`default_nettype wire

/* sfr_gpio_tb.sv */
// Expects N_REGS 4 and GPIO_W 8; pins change only between bus accesses and settle before checks
`timescale 1ns/1ps
`default_nettype none

module sfr_gpio_tb import sfr_pkg::*; ();

    localparam logic [7:0]         BASE_ADDR  = 8'h40;
    localparam logic [7:0]         BASE2_ADDR = 8'h01;
    localparam int                 N_REGS     = 4;
    localparam int                 GPIO_W     = 8;
    localparam word_t [N_REGS-1:0] INIT_STATE = {32'h0, 32'h0, 32'h0000_000F, 32'h0};

    // Cycle budget per test, four cycles per bus access, eight for one without ready
    localparam int LEN_RESET = 4;
    localparam int LEN_IMAGE = 16;
    localparam int LEN_WORD  = 120;
    localparam int LEN_BIT   = 192;
    localparam int LEN_IGN   = 60;
    localparam int LEN_PINS  = 60;
    localparam int WATCHDOG_CYCLES =
        2 * (LEN_RESET + LEN_IMAGE + LEN_WORD + LEN_BIT + LEN_IGN + LEN_PINS);

    localparam word_t PIN_MASK = word_t'({GPIO_W{1'b1}});

    logic              clk;
    logic              rst;
    logic [FWD_W-1:0]  mem_fwd;
    wire  [RET_W-1:0]  mem_ret;
    logic [GPIO_W-1:0] gpio_in;
    wire  [GPIO_W-1:0] gpio_out;
    wire  [GPIO_W-1:0] gpio_oe;

    word_t             model [N_REGS];  // Stored register image
    logic [GPIO_W-1:0] model_edge;      // Expected sticky flags
    int                errors = 0;
    int                checks = 0;
    logic              ready_q = 1'b0;

    sfr_gpio_top #(
        .BASE_ADDR  (BASE_ADDR),
        .BASE2_ADDR (BASE2_ADDR),
        .N_REGS     (N_REGS),
        .INIT_STATE (INIT_STATE),
        .GPIO_W     (GPIO_W)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .mem_fwd  (mem_fwd),
        .mem_ret  (mem_ret),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ------------------------------
    // Bus protocol monitor
    // ------------------------------
    always @(negedge clk) begin
        if (!rst) begin
            assert (!(ready_q && mem_ret[RET_READY_BIT])) else begin
                errors++;
                $display("Ready stayed high for more than one cycle");
            end
            assert (mem_ret[RET_READY_BIT] || mem_ret[RET_RDATA_MSB:RET_RDATA_LSB] == '0) else begin
                errors++;
                $display("MISMATCH rdata outside ready: got %h expected %h",
                         mem_ret[RET_RDATA_MSB:RET_RDATA_LSB], 32'h0);
            end
        end
        ready_q = mem_ret[RET_READY_BIT];
    end

    // Address built field by field from the map
    function automatic addr_t make_addr(addr_mode_t mode, int reg_n, int bit_n);
        addr_t a;
        a = '0;
        a[ADDR_BASE_MSB:ADDR_BASE_LSB]   = BASE_ADDR;
        a[ADDR_BASE2_MSB:ADDR_BASE2_LSB] = BASE2_ADDR;
        a[ADDR_MODE_MSB:ADDR_MODE_LSB]   = mode;
        if (mode == MODE_WORD) begin
            a[ADDR_WREG_MSB:ADDR_WREG_LSB] = reg_idx_t'(reg_n);
        end else begin
            a[ADDR_BREG_MSB:ADDR_BREG_LSB] = reg_idx_t'(reg_n);
            a[ADDR_WREG_MSB:ADDR_WREG_LSB] = bit_idx_t'(bit_n);  // Bit index shares word field
        end
        return a;
    endfunction

    // New bytes where strobed, old bytes elsewhere
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
        word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return r;
    endfunction

    task automatic check_value(string name, word_t got, word_t exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    // ------------------------------
    // Bus access tasks
    // ------------------------------
    task automatic bus_access(addr_t addr, word_t wdata, strb_t strb, bit expect_resp,
                              output word_t rdata);
        int cycles;
        cycles = 0;
        rdata  = '0;
        mem_fwd = '0;
        mem_fwd[FWD_VALID_BIT]               = 1'b1;
        mem_fwd[FWD_ADDR_MSB:FWD_ADDR_LSB]   = addr;
        mem_fwd[FWD_WDATA_MSB:FWD_WDATA_LSB] = wdata;
        mem_fwd[FWD_STRB_MSB:FWD_STRB_LSB]   = strb;
        do begin
            @(negedge clk);                  // Sample mid-cycle
            cycles++;
        end while (!mem_ret[RET_READY_BIT] && cycles < 5);
        checks++;
        if (expect_resp) begin
            // Valid seen at the first edge, ready in the cycle after the second
            assert (mem_ret[RET_READY_BIT] && cycles == 3) else begin
                errors++;
                $display("Ready for address %h came after %0d cycles instead of 3",
                         addr, cycles);
            end
            rdata = mem_ret[RET_RDATA_MSB:RET_RDATA_LSB];
        end else begin
            assert (!mem_ret[RET_READY_BIT]) else begin
                errors++;
                $display("Address %h got ready although it should not match", addr);
            end
        end
        @(posedge clk);
        #1;
        mem_fwd = '0;                        // Drop valid after ready
    endtask

    task automatic bus_write(addr_t addr, word_t wdata, strb_t strb);
        word_t unused;
        bus_access(addr, wdata, strb, 1'b1, unused);
    endtask

    task automatic bus_read(addr_t addr, output word_t rdata);
        bus_access(addr, 32'h0, 4'h0, 1'b1, rdata);
    endtask

    task automatic check_pins();
        check_value("gpio_out", word_t'(gpio_out), model[0] & PIN_MASK);
        check_value("gpio_oe", word_t'(gpio_oe), model[1] & PIN_MASK);
    endtask

    // Word reads of the whole map, pins assumed settled
    task automatic check_regs();
        word_t rd;
        bus_read(make_addr(MODE_WORD, 0, 0), rd);
        check_value("OUT", rd, model[0] & PIN_MASK);
        bus_read(make_addr(MODE_WORD, 1, 0), rd);
        check_value("OE", rd, model[1] & PIN_MASK);
        bus_read(make_addr(MODE_WORD, 2, 0), rd);
        check_value("IN", rd, word_t'(gpio_in));
        bus_read(make_addr(MODE_WORD, 3, 0), rd);
        check_value("EDGE", rd, word_t'(model_edge));
    endtask

    // One OE bit through the bit address, then the whole word and the pins
    task automatic compare_oe_bit(addr_mode_t mode, int b);
        word_t rd;
        bus_read(make_addr(mode, 1, b), rd);
        check_value("OE bit", rd, word_t'(model[1][b]));
        bus_read(make_addr(MODE_WORD, 1, 0), rd);
        check_value("OE", rd, model[1] & PIN_MASK);
        check_pins();
    endtask

    // New pin levels, then IN polled until the synchronizer shows them
    task automatic drive_pins(logic [GPIO_W-1:0] value);
        word_t rd;
        int    polls;
        model_edge = model_edge | (value & ~gpio_in);  // Rising pins set flags
        gpio_in    = value;
        polls      = 0;
        do begin
            bus_read(make_addr(MODE_WORD, 2, 0), rd);
            polls++;
        end while (rd != word_t'(value) && polls < 3);
        check_value("IN", rd, word_t'(value));
    endtask

    task automatic print_test_result(string name, int err_before);
        if (errors == err_before) $display("Test %s: ok", name);
        else $display("Test %s: FAILED with %0d errors", name, errors - err_before);
    endtask

    // ------------------------------
    // Watchdog
    // ------------------------------
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        word_t rd;
        word_t data;
        addr_t bad;
        int    err_start;

        data    = $urandom(19);              // Seed once
        rst     = 1'b1;
        mem_fwd = '0;
        gpio_in = '0;
        for (int r = 0; r < N_REGS; r++) model[r] = INIT_STATE[r];
        model_edge = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset image
        err_start = errors;
        check_regs();
        check_value("gpio_oe", word_t'(gpio_oe), 32'h0000_000F);
        print_test_result("reset image", err_start);

        // Byte-strobed word writes to OUT
        err_start = errors;
        for (int s = 1; s < 16; s++) begin
            data = $urandom();
            bus_write(make_addr(MODE_WORD, 0, 0), data, strb_t'(s));
            model[0] = merge_bytes(model[0], data, strb_t'(s));
            bus_read(make_addr(MODE_WORD, 0, 0), rd);
            check_value("OUT", rd, model[0] & PIN_MASK);
            check_pins();
        end
        print_test_result("byte strobes", err_start);

        // Bit set and clear on OE
        err_start = errors;
        for (int b = 0; b < GPIO_W; b++) begin
            data = $urandom();               // Write data must not matter
            bus_write(make_addr(MODE_BIT_SET, 1, b), data, 4'hF);
            model[1][b] = 1'b1;
            compare_oe_bit(MODE_BIT_SET, b);
            bus_write(make_addr(MODE_BIT_CLR, 1, b), data, 4'hF);
            model[1][b] = 1'b0;
            compare_oe_bit(MODE_BIT_CLR, b);
        end
        print_test_result("bit set and clear", err_start);

        // Ignored accesses
        err_start = errors;
        bus_write(make_addr(MODE_WORD, 1, 0), 32'h0000_00A5, 4'hF);  // Known OE image
        model[1] = 32'h0000_00A5;
        bad = make_addr(MODE_WORD, 1, 0);
        bad[ADDR_BASE_MSB:ADDR_BASE_LSB] = ~BASE_ADDR;
        bus_access(bad, 32'hFFFF_FFFF, 4'hF, 1'b0, rd);
        bad = make_addr(MODE_WORD, 1, 0);
        bad[ADDR_BASE2_MSB:ADDR_BASE2_LSB] = ~BASE2_ADDR;
        bus_access(bad, 32'hFFFF_FFFF, 4'hF, 1'b0, rd);
        bad = make_addr(MODE_WORD, 1, 0);
        bad[ADDR_ZERO_MSB:ADDR_ZERO_LSB] = 2'b01;                    // Zero field broken
        bus_access(bad, 32'hFFFF_FFFF, 4'hF, 1'b0, rd);
        bus_write(make_addr(MODE_NONE, 1, 0), 32'h0, 4'hF);          // Would clear OE bit 0
        bus_read(make_addr(MODE_NONE, 1, 0), rd);
        check_value("MODE_NONE rdata", rd, 32'h0);
        bus_write(make_addr(MODE_WORD, 5, 0), 32'hFFFF_FFFF, 4'hF);
        bus_read(make_addr(MODE_WORD, 5, 0), rd);
        check_value("reg 5 rdata", rd, 32'h0);
        check_regs();
        check_pins();
        print_test_result("ignored accesses", err_start);

        // Pin input and edge flags
        err_start = errors;
        drive_pins(8'h05);                   // Rising on pins 0 and 2
        bus_read(make_addr(MODE_WORD, 3, 0), rd);
        check_value("EDGE", rd, word_t'(model_edge));
        drive_pins(8'h00);                   // Falling pins leave the flags set
        bus_read(make_addr(MODE_WORD, 3, 0), rd);
        check_value("EDGE", rd, word_t'(model_edge));
        bus_write(make_addr(MODE_BIT_CLR, 3, 2), 32'h0, 4'hF);
        model_edge[2] = 1'b0;                // Only pin 2 flag goes
        bus_read(make_addr(MODE_WORD, 3, 0), rd);
        check_value("EDGE", rd, word_t'(model_edge));
        check_regs();
        print_test_result("pins and edge flags", err_start);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sfr_gpio.f */
sfr_pkg.sv
sfr_ctrl.sv
sfr_regfile.sv
sfr_read_mux.sv
gpio_port.sv
sfr_gpio_top.sv
sfr_gpio_tb.sv
